//--- bench/merge_config_cases.txt
# case <name> <stall 0|1> ... end; b <class> <offset> <data> <count>: offset steps in its 16-slot span, data +1
# e <mask> <type> <count>: expected records, mask and type +0x10 per further record (all hex except count)
case first_window 0
b 1 0010 a50000a5 16
e a5 a6 1
end
case filtered_beats 0
b 3 0010 000000ee 1
b 1 000f 000000dd 1
b 0 0010 000000cc 1
b 1 0020 000000bb 2
b 1 0010 000000c3 1
b 0 0011 00000099 1
b 3 0011 00000098 1
b 1 0025 00000097 1
b 1 0011 1234565a 15
e c3 5a 1
end
case late_start 0
b 2 0014 00000040 4
b 1 0008 00000030 2
b 2 0010 00000077 16
e 77 78 1
end
case stalled_windows 1
b 1 0010 00000003 448
e 03 04 28
end

//--- sim.f
design/merge_config_pkg.sv
design/sync_fifo.sv
design/setup_word_filter.sv
design/word_counter.sv
design/config_sequencer.sv
design/config_assembler.sv
design/merge_config_loader.sv
bench/tb_clock_gen.sv
bench/merge_config_loader_assertions.sv
bench/merge_config_loader_tb.sv

//--- bench/merge_config_loader_tb.sv
// testbench for the loader; runs the named cases from the case file and checks every record
module merge_config_loader_tb
    import merge_config_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NAME_W = 8 * 32;

    logic          ap_clk;
    logic          reset;
    logic          in_valid;
    logic          in_ready;
    buffer_class_t in_buffer_class;
    offset_t       in_offset;
    word_data_t    in_data;
    logic          cfg_valid;
    logic          cfg_ready;
    merge_mask_t   cfg_merge_mask;
    merge_type_t   cfg_merge_type;

    // case file contents, expanded to single beats and records
    buffer_class_t     beat_class_q[$];
    offset_t           beat_offset_q[$];
    word_data_t        beat_data_q[$];
    merge_mask_t       rec_mask_q[$];
    merge_type_t       rec_type_q[$];
    logic [NAME_W-1:0] case_name_q[$];
    bit                case_stall_q[$];
    int                case_beats_q[$];
    int                case_recs_q[$];

    // records still owed by the DUT
    merge_mask_t       exp_mask_q[$];
    merge_type_t       exp_type_q[$];

    logic [NAME_W-1:0] cur_case;
    bit                stall_mode;
    int                stall_left;
    bit                saw_backpressure;
    bit                last_slot_sent;
    int                beat_pos;
    int                rec_pos;
    int                errors;
    int                cycles;
    int                cycle_limit;

    tb_clock_gen u_tb_clock_gen (
        .ap_clk (ap_clk),
        .reset  (reset)
    );

    merge_config_loader u_merge_config_loader (.*);

    // ----------------------------------------------------------------------
    // case file
    // ----------------------------------------------------------------------
    task automatic read_cases();
        int                fd;
        int                n;
        int                k;
        int                count;
        int                stall;
        int                nb;
        int                nr;
        logic [8*128-1:0]  line;
        logic [8*8-1:0]    kw;
        logic [NAME_W-1:0] name;
        logic [31:0]       a;
        logic [31:0]       b;
        logic [31:0]       c;
        fd = $fopen("bench/merge_config_cases.txt", "r");
        nb = 0;
        nr = 0;
        assert (fd != 0) else begin
            errors++;
            $display("could not open the case file");
        end
        while (fd != 0 && !$feof(fd)) begin
            line = '0;
            kw = '0;
            n = $fgets(line, fd);
            n = $sscanf(line, "%s", kw);
            if (kw == "case") begin
                n = $sscanf(line, "%s %s %d", kw, name, stall);
                case_name_q.push_back(name);
                case_stall_q.push_back(stall != 0);
                nb = 0;
                nr = 0;
            end else if (kw == "b") begin
                n = $sscanf(line, "%s %h %h %h %d", kw, a, b, c, count);
                // offset walks its 16-slot span, data counts up
                for (k = 0; k < count; k++) begin
                    beat_class_q.push_back(buffer_class_t'(a));
                    beat_offset_q.push_back(offset_t'(b + (k % SEQ_LEN)));
                    beat_data_q.push_back(word_data_t'(c + k));
                end
                nb += count;
            end else if (kw == "e") begin
                n = $sscanf(line, "%s %h %h %d", kw, a, b, count);
                for (k = 0; k < count; k++) begin
                    rec_mask_q.push_back(merge_mask_t'(a + SEQ_LEN * k));
                    rec_type_q.push_back(merge_type_t'(b + SEQ_LEN * k));
                end
                nr += count;
            end else if (kw == "end") begin
                case_beats_q.push_back(nb);
                case_recs_q.push_back(nr);
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
    endtask

    // ----------------------------------------------------------------------
    // stimulus
    // ----------------------------------------------------------------------
    // called on a falling edge, returns on the falling edge after the transfer
    task automatic send_beat(input int idx);
        bit taken;
        in_valid        = 1'b1;
        in_buffer_class = beat_class_q[idx];
        in_offset       = beat_offset_q[idx];
        in_data         = beat_data_q[idx];
        taken           = 1'b0;
        while (!taken) begin
            // in_ready does not depend on the beat on offer
            taken = in_ready;
            if (!taken) begin
                saw_backpressure = 1'b1;
            end
            @(posedge ap_clk);
            @(negedge ap_clk);
        end
        if ((in_buffer_class == CLASS_CU_SETUP || in_buffer_class == CLASS_ENGINE_SETUP) &&
            in_offset == SEQ_BASE + SEQ_LEN - 1) begin
            last_slot_sent = 1'b1;
        end
    endtask

    task automatic run_case(input int ci);
        int k;
        int drain;
        cur_case         = case_name_q[ci];
        stall_mode       = case_stall_q[ci];
        saw_backpressure = 1'b0;
        for (k = 0; k < case_recs_q[ci]; k++) begin
            exp_mask_q.push_back(rec_mask_q[rec_pos + k]);
            exp_type_q.push_back(rec_type_q[rec_pos + k]);
        end
        rec_pos += case_recs_q[ci];
        for (k = 0; k < case_beats_q[ci]; k++) begin
            send_beat(beat_pos + k);
        end
        beat_pos += case_beats_q[ci];
        in_valid = 1'b0;
        drain = 0;
        while (exp_mask_q.size() != 0 && drain < 20 * case_beats_q[ci] + 100) begin
            @(negedge ap_clk);
            drain++;
        end
        assert (exp_mask_q.size() == 0) else begin
            errors++;
            $display("case %0s: %0d expected records never arrived", cur_case, exp_mask_q.size());
        end
        exp_mask_q.delete();
        exp_type_q.delete();
        if (case_stall_q[ci]) begin
            assert (saw_backpressure) else begin
                errors++;
                $display("case %0s: in_ready never dropped while the output stalled", cur_case);
            end
        end
        stall_mode = 1'b0;
    endtask

    // long random stalls so the record queue backs up
    always @(negedge ap_clk) begin
        if (!stall_mode) begin
            cfg_ready = 1'b1;
        end else if (stall_left > 0) begin
            cfg_ready = 1'b0;
            stall_left--;
        end else begin
            cfg_ready = 1'b1;
            stall_left = $urandom_range(200, 60);
        end
    end

    // ----------------------------------------------------------------------
    // record checks and watchdog
    // ----------------------------------------------------------------------
    always @(posedge ap_clk) begin
        if (!reset && cfg_valid && cfg_ready) begin
            assert (last_slot_sent) else begin
                errors++;
                $display("record appeared before any complete window was sent");
            end
            assert (exp_mask_q.size() != 0) else begin
                errors++;
                $display("case %0s: record %02h %02h arrived with none expected",
                         cur_case, cfg_merge_mask, cfg_merge_type);
            end
            if (exp_mask_q.size() != 0) begin
                assert (cfg_merge_mask == exp_mask_q[0]) else begin
                    errors++;
                    $display("mismatch %0s mask expected %02h actual %02h",
                             cur_case, exp_mask_q[0], cfg_merge_mask);
                end
                assert (cfg_merge_type == exp_type_q[0]) else begin
                    errors++;
                    $display("mismatch %0s type expected %02h actual %02h",
                             cur_case, exp_type_q[0], cfg_merge_type);
                end
                void'(exp_mask_q.pop_front());
                void'(exp_type_q.pop_front());
            end
        end
    end

    always @(posedge ap_clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("run stopped after %0d cycles in case %0s", cycles, cur_case);
            $display("Checks failed");
            $finish;
        end
    end

    initial begin
        in_valid         = 1'b0;
        in_buffer_class  = '0;
        in_offset        = '0;
        in_data          = '0;
        cfg_ready        = 1'b0;
        stall_mode       = 1'b0;
        stall_left       = 0;
        saw_backpressure = 1'b0;
        last_slot_sent   = 1'b0;
        cur_case         = '0;
        beat_pos         = 0;
        rec_pos          = 0;
        errors           = 0;
        cycles           = 0;
        cycle_limit      = 500;
        void'($urandom(60432));
        read_cases();
        cycle_limit = 30 * beat_data_q.size() + 500;
        assert (case_name_q.size() > 0) else begin
            errors++;
            $display("the case file held no cases");
        end
        @(negedge ap_clk);
        while (reset) begin
            @(negedge ap_clk);
        end
        for (int ci = 0; ci < case_name_q.size(); ci++) begin
            run_case(ci);
        end
        // catch a stray record after the last case
        repeat (40) @(negedge ap_clk);
        // failures of the bound handshake and reset assertions
        errors += u_merge_config_loader.u_merge_config_loader_assertions.fail_count;
        $display("%0d errors over %0d cases", errors, case_name_q.size());
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule : merge_config_loader_tb

//--- bench/merge_config_loader_assertions.sv
// concurrent checks on the record handshake and the reset state, bound into the loader top level
module merge_config_loader_assertions
    import merge_config_pkg::*;
(
    input logic        ap_clk,
    input logic        reset,
    input logic        in_ready,
    input logic        cfg_valid,
    input logic        cfg_ready,
    input merge_mask_t cfg_merge_mask,
    input merge_type_t cfg_merge_type
);
    timeunit 1ns;
    timeprecision 100ps;

    // number of failed assertions so far
    int fail_count = 0;

    // a waiting record leaves only through a handshake
    property valid_held;
        @(posedge ap_clk) disable iff (reset)
        cfg_valid && !cfg_ready |=> cfg_valid;
    endproperty

    property fields_held;
        @(posedge ap_clk) disable iff (reset)
        cfg_valid && !cfg_ready |=> $stable(cfg_merge_mask) && $stable(cfg_merge_type);
    endproperty

    // queues empty and input register free right after reset
    property reset_state;
        @(posedge ap_clk) reset |=> !cfg_valid && in_ready;
    endproperty

    assert property (valid_held) else begin
        fail_count++;
        $error("cfg_valid fell without a handshake");
    end
    assert property (fields_held) else begin
        fail_count++;
        $error("record fields changed while cfg_valid waited");
    end
    assert property (reset_state) else begin
        fail_count++;
        $error("wrong cfg_valid or in_ready after reset");
    end

endmodule : merge_config_loader_assertions

bind merge_config_loader merge_config_loader_assertions u_merge_config_loader_assertions (.*);

//--- bench/tb_clock_gen.sv
// clock and reset source for the loader testbench; 10 ns ap_clk and a two-cycle reset
module tb_clock_gen (
    output logic ap_clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        ap_clk = 1'b0;
        forever #5 ap_clk = ~ap_clk;
    end

    // high across the first two rising edges, released on a falling edge
    initial begin
        reset = 1'b1;
        repeat (2) @(negedge ap_clk);
        reset = 1'b0;
    end

endmodule : tb_clock_gen

//--- design/merge_config_loader.sv
// top level of the merge configuration loader; response beats in, configuration records out
module merge_config_loader
    import merge_config_pkg::*;
(
    input  logic          ap_clk,
    input  logic          reset,
    // response word channel
    input  logic          in_valid,
    output logic          in_ready,
    input  buffer_class_t in_buffer_class,
    input  offset_t       in_offset,
    input  word_data_t    in_data,
    // configuration record channel
    output logic          cfg_valid,
    input  logic          cfg_ready,
    output merge_mask_t   cfg_merge_mask,
    output merge_type_t   cfg_merge_type
);

    logic        word_valid;
    logic        word_first;
    word_data_t  word_data;
    logic        word_take;
    logic        count_clear;
    logic        count_step;
    slot_count_t slot;
    logic        at_last;
    logic        capture;
    logic        emit;
    logic        emit_ready;

    // ----------------------------------------------------------------------
    // datapath
    // ----------------------------------------------------------------------
    setup_word_filter u_setup_word_filter (
        .ap_clk          (ap_clk),
        .reset           (reset),
        .in_valid        (in_valid),
        .in_ready        (in_ready),
        .in_buffer_class (in_buffer_class),
        .in_offset       (in_offset),
        .in_data         (in_data),
        .word_valid      (word_valid),
        .word_first      (word_first),
        .word_data       (word_data),
        .word_take       (word_take)
    );

    config_assembler u_config_assembler (
        .ap_clk         (ap_clk),
        .reset          (reset),
        .word_data      (word_data),
        .slot           (slot),
        .capture        (capture),
        .emit           (emit),
        .emit_ready     (emit_ready),
        .cfg_valid      (cfg_valid),
        .cfg_merge_mask (cfg_merge_mask),
        .cfg_merge_type (cfg_merge_type),
        .cfg_ready      (cfg_ready)
    );

    // ----------------------------------------------------------------------
    // control
    // ----------------------------------------------------------------------
    config_sequencer u_config_sequencer (
        .ap_clk      (ap_clk),
        .reset       (reset),
        .word_valid  (word_valid),
        .word_first  (word_first),
        .word_take   (word_take),
        .count_clear (count_clear),
        .count_step  (count_step),
        .at_last     (at_last),
        .capture     (capture),
        .emit        (emit),
        .emit_ready  (emit_ready)
    );

    word_counter u_word_counter (
        .ap_clk      (ap_clk),
        .reset       (reset),
        .count_clear (count_clear),
        .count_step  (count_step),
        .slot        (slot),
        .at_last     (at_last)
    );

endmodule : merge_config_loader

//--- design/config_assembler.sv
// holds mask and type captured from their slots and queues finished records for output
module config_assembler
    import merge_config_pkg::*;
(
    input  logic        ap_clk,
    input  logic        reset,
    input  word_data_t  word_data,
    input  slot_count_t slot,
    input  logic        capture,
    input  logic        emit,
    output logic        emit_ready,
    output logic        cfg_valid,
    output merge_mask_t cfg_merge_mask,
    output merge_type_t cfg_merge_type,
    input  logic        cfg_ready
);

    localparam int RW = $bits(merge_mask_t) + $bits(merge_type_t);

    merge_mask_t mask_hold;
    merge_type_t type_hold;

    // ----------------------------------------------------------------------
    // field capture
    // ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (capture) begin
            case (slot)
                slot_count_t'(SLOT_MASK): begin
                    mask_hold <= word_data[$bits(merge_mask_t)-1:0];
                end
                slot_count_t'(SLOT_TYPE): begin
                    type_hold <= word_data[$bits(merge_type_t)-1:0];
                end
                // reserved slots
                default: begin
                end
            endcase
        end
    end

    // ----------------------------------------------------------------------
    // record queue
    // ----------------------------------------------------------------------
    sync_fifo #(.WIDTH(RW), .DEPTH(FIFO_DEPTH)) u_record_fifo (
        .ap_clk   (ap_clk),
        .reset    (reset),
        .wr_valid (emit),
        .wr_ready (emit_ready),
        .wr_data  ({mask_hold, type_hold}),
        .rd_valid (cfg_valid),
        .rd_ready (cfg_ready),
        .rd_data  ({cfg_merge_mask, cfg_merge_type})
    );

endmodule : config_assembler

//--- design/config_sequencer.sv
// FSM that finds the window start, steers capture and counting, and emits one record per window
module config_sequencer
    import merge_config_pkg::*;
(
    input  logic ap_clk,
    input  logic reset,
    input  logic word_valid,
    input  logic word_first,
    output logic word_take,
    output logic count_clear,
    output logic count_step,
    input  logic at_last,
    output logic capture,
    output logic emit,
    input  logic emit_ready
);

    seq_state_t state;
    seq_state_t state_next;

    // ----------------------------------------------------------------------
    // word handshake and capture control
    // ----------------------------------------------------------------------
    // one word per cycle unless a record is waiting
    assign word_take = word_valid & (state != SEQ_EMIT);

    // idle: only a first word starts a sequence, others are dropped
    assign capture = word_take & ((state == SEQ_COLLECT) | word_first);

    assign count_step  = capture;
    assign emit        = (state == SEQ_EMIT);
    assign count_clear = emit & emit_ready;

    // ----------------------------------------------------------------------
    // next state
    // ----------------------------------------------------------------------
    always_comb begin
        state_next = state;
        case (state)
            SEQ_IDLE: begin
                if (word_take && word_first) begin
                    state_next = SEQ_COLLECT;
                end
            end
            SEQ_COLLECT: begin
                // last slot closes the sequence
                if (word_take && at_last) begin
                    state_next = SEQ_EMIT;
                end
            end
            SEQ_EMIT: begin
                if (emit_ready) begin
                    state_next = SEQ_IDLE;
                end
            end
            default: begin
                state_next = SEQ_IDLE;
            end
        endcase
    end

    always_ff @(posedge ap_clk) begin
        if (reset) begin
            state <= SEQ_IDLE;
        end else begin
            state <= state_next;
        end
    end

endmodule : config_sequencer

//--- design/word_counter.sv
// slot index of the next word in a sequence, with a flag on the last slot
module word_counter
    import merge_config_pkg::*;
(
    input  logic        ap_clk,
    input  logic        reset,
    input  logic        count_clear,
    input  logic        count_step,
    output slot_count_t slot,
    output logic        at_last
);

    // ----------------------------------------------------------------------
    // slot register
    // ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (reset) begin
            slot <= '0;
        end else if (count_clear) begin
            // clear wins over a step in the same cycle
            slot <= '0;
        end else if (count_step) begin
            slot <= slot + 1'b1;
        end
    end

    // last slot of the window
    assign at_last = (slot == slot_count_t'(SEQ_LEN - 1));

endmodule : word_counter

//--- design/setup_word_filter.sv
// registers response beats, keeps setup words inside the engine window and queues them
module setup_word_filter
    import merge_config_pkg::*;
(
    input  logic          ap_clk,
    input  logic          reset,
    input  logic          in_valid,
    output logic          in_ready,
    input  buffer_class_t in_buffer_class,
    input  offset_t       in_offset,
    input  word_data_t    in_data,
    output logic          word_valid,
    output logic          word_first,
    output word_data_t    word_data,
    input  logic          word_take
);

    localparam int QW = 1 + $bits(word_data_t);

    logic          beat_valid;
    buffer_class_t beat_class;
    offset_t       beat_offset;
    word_data_t    beat_data;
    logic          class_ok;
    logic          window_ok;
    logic          keep;
    logic          leave;
    logic          q_wr_ready;

    // ----------------------------------------------------------------------
    // input register
    // ----------------------------------------------------------------------
    // beat leaves when dropped, or when the queue takes it
    assign leave    = beat_valid & (~keep | q_wr_ready);
    assign in_ready = ~beat_valid | leave;

    always_ff @(posedge ap_clk) begin
        if (reset) begin
            beat_valid <= 1'b0;
        end else if (in_ready) begin
            beat_valid <= in_valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (in_ready) begin
            beat_class  <= in_buffer_class;
            beat_offset <= in_offset;
            beat_data   <= in_data;
        end
    end

    // ----------------------------------------------------------------------
    // class and window filter
    // ----------------------------------------------------------------------
    assign class_ok  = (beat_class == buffer_class_t'(CLASS_CU_SETUP)) |
                       (beat_class == buffer_class_t'(CLASS_ENGINE_SETUP));
    assign window_ok = (beat_offset >= offset_t'(SEQ_BASE)) &
                       (beat_offset <  offset_t'(SEQ_BASE + SEQ_LEN));
    assign keep      = class_ok & window_ok;

    // first-slot flag rides beside the data
    sync_fifo #(.WIDTH(QW), .DEPTH(FIFO_DEPTH)) u_word_fifo (
        .ap_clk   (ap_clk),
        .reset    (reset),
        .wr_valid (beat_valid & keep),
        .wr_ready (q_wr_ready),
        .wr_data  ({(beat_offset == offset_t'(SEQ_BASE)), beat_data}),
        .rd_valid (word_valid),
        .rd_ready (word_take),
        .rd_data  ({word_first, word_data})
    );

endmodule : setup_word_filter

//--- design/sync_fifo.sv
// first-word-fall-through queue with valid/ready on both sides, for response words and records
module sync_fifo
    import merge_config_pkg::*;
#(
    parameter int WIDTH = 8,
    parameter int DEPTH = FIFO_DEPTH
) (
    input  logic             ap_clk,
    input  logic             reset,
    input  logic             wr_valid,
    output logic             wr_ready,
    input  logic [WIDTH-1:0] wr_data,
    output logic             rd_valid,
    input  logic             rd_ready,
    output logic [WIDTH-1:0] rd_data
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_wr;
    logic             do_rd;

    assign wr_ready = (count != CNT_W'(DEPTH));
    assign rd_valid = (count != '0);
    // head word shown while not empty
    assign rd_data  = mem[rd_ptr];

    assign do_wr = wr_valid & wr_ready;
    assign do_rd = rd_valid & rd_ready;

    // storage, no reset needed
    always_ff @(posedge ap_clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // ----------------------------------------------------------------------
    // pointers and occupancy
    // ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves count unchanged
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule : sync_fifo

//--- design/merge_config_pkg.sv
// shared widths, types, window constants and sequencer states; imported by every loader module
package merge_config_pkg;

    // ----------------------------------------------------------------------
    // field types
    // ----------------------------------------------------------------------
    // buffer class code carried with each response word
    typedef logic [1:0]  buffer_class_t;
    // offset in slot units, no shift applied
    typedef logic [15:0] offset_t;
    typedef logic [31:0] word_data_t;

    typedef logic [7:0]  merge_mask_t;
    typedef logic [7:0]  merge_type_t;

    // slot index within one sequence
    typedef logic [3:0]  slot_count_t;

    // ----------------------------------------------------------------------
    // buffer classes and window
    // ----------------------------------------------------------------------
    localparam int CLASS_CU_SETUP     = 1;
    localparam int CLASS_ENGINE_SETUP = 2;

    // first offset of this engine's window
    localparam int SEQ_BASE = 16;
    // slots per sequence
    localparam int SEQ_LEN  = 16;

    // slots that carry configuration fields, the rest are reserved
    localparam int SLOT_MASK = 0;
    localparam int SLOT_TYPE = 1;

    // depth of the response and record queues
    localparam int FIFO_DEPTH = 16;

    // ----------------------------------------------------------------------
    // sequencer states
    // ----------------------------------------------------------------------
    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_COLLECT,
        SEQ_EMIT
    } seq_state_t;

endpackage : merge_config_pkg
